/* arcade_ctrl.f */
+incdir+common
common/arcade_ctrl_pkg.sv
common/joy_bus_if.sv
joy_reader/joy_slot_timer.sv
joy_reader/joy_sequencer.sv
joy_reader/joy_capture.sv
hdl/control_map.sv
hdl/arcade_ctrl_top.sv
test/arcade_ctrl_assert.sv
test/arcade_ctrl_tb.sv

/* common/arcade_ctrl_cfg.svh */
// Arcade controller front end configuration
// Frame geometry of the joystick shifter and power-on warm-up length

`ifndef ARCADE_CTRL_CFG_SVH
`define ARCADE_CTRL_CFG_SVH

// ena_x cycles per joystick frame, load slot included
`define ARC_FRAME_SLOTS 26

// First slot with a data bit, slots 2 to 25 carry 24 bits
`define ARC_FIRST_SLOT 2

// Power-on delay after PLL lock, fits the 8-bit slot counter
`define ARC_WARMUP_CYCLES 256

`endif

/* common/arcade_ctrl_pkg.sv */
// Arcade controller front end shared types
// Pad word layout, sequencer states and the slot-to-bit map entry
// used by the joystick reader and the control mapping

package arcade_ctrl_pkg;

  // One 12-button pad, all buttons active low
  typedef struct packed {
    logic menu;    // 11
    logic aux_c;   // 10
    logic coin;    // 9
    logic start;   // 8
    logic aux_b;   // 7
    logic aux_a;   // 6
    logic fire2;   // 5
    logic fire1;   // 4
    logic up;      // 3
    logic down;    // 2
    logic left;    // 1
    logic right;   // 0
  } joy_word_t;

  // Bit positions inside joy_word_t
  typedef enum logic [3:0] {
    JB_RIGHT = 4'd0,
    JB_LEFT  = 4'd1,
    JB_DOWN  = 4'd2,
    JB_UP    = 4'd3,
    JB_FIRE1 = 4'd4,
    JB_FIRE2 = 4'd5,
    JB_AUX_A = 4'd6,
    JB_AUX_B = 4'd7,
    JB_START = 4'd8,
    JB_COIN  = 4'd9,
    JB_AUX_C = 4'd10,
    JB_MENU  = 4'd11
  } joy_bit_e;

  // Joystick shifter sequencer
  typedef enum logic [1:0] {
    WARMUP = 2'd0,
    LOAD   = 2'd1,
    SHIFT  = 2'd2
  } seq_state_t;

  // Slot number inside one frame
  typedef logic [4:0] slot_t;

  // Where the bit of one slot lands
  typedef struct packed {
    logic     hit;     // Slot carries pad data
    logic     pad_b;   // 0 = pad A, 1 = pad B
    joy_bit_e idx;
  } slot_map_t;

endpackage

/* common/joy_bus_if.sv */
// Joystick reader internal bus
// Slot position and frame control between sequencer, slot timer
// and capture. Plain levels and one-cycle pulses

`timescale 1ns/1ps

interface joy_bus_if;
  import arcade_ctrl_pkg::*;

  slot_t slot;        // Current slot, from the timer
  logic  wrap;        // Terminal count reached
  logic  clear;       // Force the timer back to 0
  logic  frame_mode;  // Count frame slots, else warm-up cycles
  logic  sample_en;   // Data slot, capture joy_data
  logic  publish;     // Last slot, frame complete

  modport seq (
    input  slot, wrap,
    output clear, frame_mode, sample_en, publish
  );

  modport timer (
    input  clear, frame_mode,
    output slot, wrap
  );

  modport capture (
    input  slot, sample_en, publish
  );

endinterface

/* hdl/arcade_ctrl_top.sv */
// Arcade controller front end
// Serial joystick reader plus control mapping for the arcade core.
// Warm-up after PLL lock, then one pad frame every 26 ena_x cycles

`timescale 1ns/1ps

module arcade_ctrl_top (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic       joy_data,
  input  logic [1:0] btn,
  input  logic       key_reset,
  input  logic       master_reset,
  input  logic       key_mode,
  input  logic       video_toggle,
  input  logic [1:0] scandbl_ctrl,   // From the scan doubler register
  output logic       joy_load,
  output logic [5:0] stick_a,
  output logic [5:0] stick_b,
  output logic [1:0] start,
  output logic [1:0] coin,
  output logic       machine_reset,
  output logic       reboot,
  output logic       tv15khz_mode,
  output logic [1:0] led
);
  import arcade_ctrl_pkg::*;

  joy_word_t pad_a;
  joy_word_t pad_b;
  logic      warming;

  joy_bus_if bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Joystick reader
  ////////////////////////////////////////////////////////////////////////////

  joy_sequencer joy_sequencer_i (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .bus      (bus.seq),
    .joy_load (joy_load),
    .warming  (warming)
  );

  joy_slot_timer joy_slot_timer_i (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .bus      (bus.timer)
  );

  joy_capture joy_capture_i (
    .ena_x    (ena_x),
    .pll_lckd (pll_lckd),
    .bus      (bus.capture),
    .joy_data (joy_data),
    .pad_a    (pad_a),
    .pad_b    (pad_b)
  );

  // Machine side
  control_map control_map_i (
    .ena_x         (ena_x),
    .pll_lckd      (pll_lckd),
    .pad_a         (pad_a),
    .pad_b         (pad_b),
    .warming       (warming),
    .btn           (btn),
    .key_reset     (key_reset),
    .master_reset  (master_reset),
    .key_mode      (key_mode),
    .video_toggle  (video_toggle),
    .scandbl_ctrl  (scandbl_ctrl),
    .stick_a       (stick_a),
    .stick_b       (stick_b),
    .start         (start),
    .coin          (coin),
    .machine_reset (machine_reset),
    .reboot        (reboot),
    .tv15khz_mode  (tv15khz_mode),
    .led           (led)
  );

endmodule

/* hdl/control_map.sv */
// Machine control mapping
// Turns the published pad words, board buttons and keyboard switches
// into the arcade machine's control inputs, one register stage

`timescale 1ns/1ps

module control_map (
  input  logic                       ena_x,
  input  logic                       pll_lckd,
  input  arcade_ctrl_pkg::joy_word_t pad_a,
  input  arcade_ctrl_pkg::joy_word_t pad_b,
  input  logic                       warming,
  input  logic [1:0]                 btn,           // Board buttons, active low
  input  logic                       key_reset,
  input  logic                       master_reset,
  input  logic                       key_mode,
  input  logic                       video_toggle,
  input  logic [1:0]                 scandbl_ctrl,
  output logic [5:0]                 stick_a,
  output logic [5:0]                 stick_b,
  output logic [1:0]                 start,
  output logic [1:0]                 coin,
  output logic                       machine_reset,
  output logic                       reboot,
  output logic                       tv15khz_mode,
  output logic [1:0]                 led
);

  ////////////////////////////////////////////////////////////////////////////
  // Player controls
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      stick_a <= '1;
      stick_b <= '1;
      start   <= '1;
      coin    <= '1;
    end else begin
      stick_a <= pad_a[5:0];                     // Fire2 down to right
      stick_b <= pad_b[5:0];
      start   <= {pad_b.start, pad_a.start};
      coin    <= {pad_b.coin, pad_a.coin & btn[0]};   // btn[0] doubles as coin 1
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Machine and board controls
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      machine_reset <= 1'b1;   // Machine held until warm-up ends
      reboot        <= 1'b0;
      tv15khz_mode  <= 1'b0;
      led           <= 2'b00;
    end else begin
      machine_reset <= warming | key_reset | ~pad_a.menu | ~btn[1];
      reboot        <= master_reset | ~pad_b.menu;
      // 15 kHz unless the scan doubler is on, toggle from keyboard
      tv15khz_mode  <= ~scandbl_ctrl[1] ^ video_toggle;
      led[0]        <= key_mode;
      led[1]        <= scandbl_ctrl[0] ^ video_toggle;   // RGB or VGA
    end
  end

endmodule

/* joy_reader/joy_capture.sv */
// Joystick bit capture
// Serial shifter bits go into shadow pad words, slot by slot.
// At the end of each frame both pads are published in one go

`timescale 1ns/1ps

module joy_capture (
  input  logic ena_x,
  input  logic pll_lckd,
  joy_bus_if.capture bus,
  input  logic joy_data,
  output arcade_ctrl_pkg::joy_word_t pad_a,
  output arcade_ctrl_pkg::joy_word_t pad_b
);
  import arcade_ctrl_pkg::*;

  joy_word_t shadow_a;
  joy_word_t shadow_b;
  joy_word_t shadow_a_nxt;
  joy_word_t shadow_b_nxt;
  slot_map_t map;

  ////////////////////////////////////////////////////////////////////////////
  // Slot map of the board shifter
  ////////////////////////////////////////////////////////////////////////////

  function automatic slot_map_t map_slot(input slot_t s);
    slot_map_t m;
    logic      pb;
    m  = '{hit: 1'b0, pad_b: 1'b0, idx: JB_RIGHT};
    pb = (s >= 5'd10) && (s <= 5'd21);   // Middle of the frame is pad B
    case (s)
      5'd2, 5'd10:  m = '{hit: 1'b1, pad_b: pb, idx: JB_START};
      5'd3, 5'd11:  m = '{hit: 1'b1, pad_b: pb, idx: JB_AUX_A};
      5'd4, 5'd12:  m = '{hit: 1'b1, pad_b: pb, idx: JB_FIRE2};
      5'd5, 5'd13:  m = '{hit: 1'b1, pad_b: pb, idx: JB_FIRE1};
      5'd6, 5'd14:  m = '{hit: 1'b1, pad_b: pb, idx: JB_UP};
      5'd7, 5'd15:  m = '{hit: 1'b1, pad_b: pb, idx: JB_DOWN};
      5'd8, 5'd16:  m = '{hit: 1'b1, pad_b: pb, idx: JB_LEFT};
      5'd9, 5'd17:  m = '{hit: 1'b1, pad_b: pb, idx: JB_RIGHT};
      5'd18, 5'd22: m = '{hit: 1'b1, pad_b: pb, idx: JB_AUX_C};
      5'd19, 5'd23: m = '{hit: 1'b1, pad_b: pb, idx: JB_MENU};
      5'd20, 5'd24: m = '{hit: 1'b1, pad_b: pb, idx: JB_COIN};
      5'd21, 5'd25: m = '{hit: 1'b1, pad_b: pb, idx: JB_AUX_B};
      default:      m.hit = 1'b0;             // Load and idle slots
    endcase
    return m;
  endfunction

  assign map = map_slot(bus.slot);

  ////////////////////////////////////////////////////////////////////////////
  // Shadow words
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    shadow_a_nxt = shadow_a;
    shadow_b_nxt = shadow_b;
    if (bus.sample_en && map.hit) begin
      if (map.pad_b) begin
        shadow_b_nxt[map.idx] = joy_data;
      end else begin
        shadow_a_nxt[map.idx] = joy_data;
      end
    end
  end

  // Filled slot by slot during the frame
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      shadow_a <= '1;
      shadow_b <= '1;
    end else begin
      shadow_a <= shadow_a_nxt;
      shadow_b <= shadow_b_nxt;
    end
  end

  // Published words, last bit of the frame included
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      pad_a <= '1;   // Nothing pressed
      pad_b <= '1;
    end else if (bus.publish) begin
      pad_a <= shadow_a_nxt;
      pad_b <= shadow_b_nxt;
    end
  end

endmodule

/* joy_reader/joy_sequencer.sv */
// Joystick shifter sequencer
// Holds the board in warm-up after PLL lock, then runs back to back
// frames of one load slot followed by the shift slots

`timescale 1ns/1ps

`include "arcade_ctrl_cfg.svh"

module joy_sequencer (
  input  logic ena_x,
  input  logic pll_lckd,
  joy_bus_if.seq bus,
  output logic joy_load,   // Active low shifter load
  output logic warming
);
  import arcade_ctrl_pkg::*;

  localparam slot_t FIRST_SLOT = slot_t'(`ARC_FIRST_SLOT);

  seq_state_t state;
  seq_state_t state_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      state <= WARMUP;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      WARMUP: begin
        if (bus.wrap) begin
          state_nxt = LOAD;   // Delay expired
        end
      end
      LOAD: begin
        state_nxt = SHIFT;    // Load lasts one slot
      end
      SHIFT: begin
        if (bus.wrap) begin
          state_nxt = LOAD;   // Next frame starts right away
        end
      end
      default: begin
        state_nxt = WARMUP;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Decoded controls
  ////////////////////////////////////////////////////////////////////////////

  // Leaving warm-up starts the frame count at slot 0
  assign bus.clear      = (state == WARMUP) && bus.wrap;
  assign bus.frame_mode = (state != WARMUP);

  assign bus.sample_en  = (state == SHIFT) && (bus.slot >= FIRST_SLOT);
  assign bus.publish    = (state == SHIFT) && bus.wrap;   // Slot 25

  assign joy_load = (state != LOAD);
  assign warming  = (state == WARMUP);

endmodule

/* joy_reader/joy_slot_timer.sv */
// Joystick slot timer
// One 8-bit counter serves both the power-on warm-up and the frame
// slots. wrap marks the terminal count of the current mode

`timescale 1ns/1ps

`include "arcade_ctrl_cfg.svh"

module joy_slot_timer (
  input  logic ena_x,
  input  logic pll_lckd,
  joy_bus_if.timer bus
);

  localparam logic [7:0] FRAME_TC  = 8'(`ARC_FRAME_SLOTS - 1);
  localparam logic [7:0] WARMUP_TC = 8'(`ARC_WARMUP_CYCLES - 1);

  logic [7:0] count;
  logic [7:0] term_count;

  assign term_count = bus.frame_mode ? FRAME_TC : WARMUP_TC;
  assign bus.wrap   = (count == term_count);

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      count <= 8'd0;
    end else if (bus.clear || bus.wrap) begin
      count <= 8'd0;
    end else begin
      count <= count + 8'd1;
    end
  end

  // Frame slots never exceed 25, low bits are enough
  assign bus.slot = count[4:0];

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the arcade controller testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module arcade_ctrl_tb -Mdir obj_dir -o arcade_ctrl_sim \
  -f arcade_ctrl.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/arcade_ctrl_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "Pass message not found"
exit 1

/* test/arcade_ctrl_assert.sv */
// Joystick sequencer protocol assertions
// Load strobe width, frame spacing and publish timing, bound to the sequencer

`timescale 1ns/1ps

`include "arcade_ctrl_cfg.svh"

module arcade_ctrl_assert (
  input logic                         ena_x,
  input logic                         pll_lckd,
  input logic                         joy_load,
  input logic                         publish,
  input arcade_ctrl_pkg::seq_state_t  state
);
  import arcade_ctrl_pkg::*;

  logic       load_q;
  logic       load_fall;
  logic       seen_fall;
  logic       frame_end;    // Last slot of a frame
  logic [7:0] since_fall;   // Cycles since the last load fall

  assign load_fall = load_q && !joy_load;
  assign frame_end = seen_fall && (since_fall == 8'(`ARC_FRAME_SLOTS - 1));

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      load_q     <= 1'b1;
      seen_fall  <= 1'b0;
      since_fall <= 8'd0;
    end else begin
      load_q <= joy_load;
      if (load_fall) begin
        seen_fall  <= 1'b1;
        since_fall <= 8'd1;
      end else if (since_fall != 8'hff) begin
        since_fall <= since_fall + 8'd1;   // Saturates
      end
    end
  end

  load_pulse: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    load_fall |=> joy_load)
    else $error("joy_load low for more than one cycle");

  frame_gap: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (load_fall && seen_fall) |-> (since_fall == 8'(`ARC_FRAME_SLOTS)))
    else $error("joy_load falls not one frame apart");

  publish_state: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    publish |-> (state == SHIFT) && frame_end)
    else $error("publish outside the last shift slot of a frame");

  publish_every: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    frame_end |-> publish)
    else $error("frame ended without publish");

endmodule

bind joy_sequencer arcade_ctrl_assert arcade_ctrl_assert_i (
  .ena_x    (ena_x),
  .pll_lckd (pll_lckd),
  .joy_load (joy_load),
  .publish  (bus.publish),
  .state    (state)
);

/* test/arcade_ctrl_tb.sv */
// Arcade controller front end testbench
// Drives random joystick frames and board inputs into the DUT and
// compares the machine controls with a model of the pad and control rules

`timescale 1ns/1ps

`include "arcade_ctrl_cfg.svh"

module arcade_ctrl_tb;
  import arcade_ctrl_pkg::*;

  // Board buttons and keyboard switches, applied together
  typedef struct packed {
    logic [1:0] btn;
    logic       key_reset;
    logic       master_reset;
    logic       key_mode;
    logic       video_toggle;
    logic [1:0] scandbl_ctrl;
  } side_t;

  localparam side_t SIDE_IDLE = '{
    btn: 2'b11, key_reset: 1'b0, master_reset: 1'b0,
    key_mode: 1'b0, video_toggle: 1'b0, scandbl_ctrl: 2'b00
  };
  localparam joy_word_t PAD_IDLE = 12'hfff;   // Nothing pressed

  logic       ena_x;
  logic       pll_lckd;
  logic       joy_data;
  logic [1:0] btn;
  logic       key_reset;
  logic       master_reset;
  logic       key_mode;
  logic       video_toggle;
  logic [1:0] scandbl_ctrl;
  logic       joy_load;
  logic [5:0] stick_a;
  logic [5:0] stick_b;
  logic [1:0] start;
  logic [1:0] coin;
  logic       machine_reset;
  logic       reboot;
  logic       tv15khz_mode;
  logic [1:0] led;

  int        check_errors;
  int        protocol_errors;
  int        timeout_errors;
  bit        aborted;
  joy_word_t exp_a;   // Model of the published pad words
  joy_word_t exp_b;

  arcade_ctrl_top arcade_ctrl_top_i (.*);

  always #2 ena_x = ~ena_x;

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers and model
  ////////////////////////////////////////////////////////////////////////////

  function automatic joy_word_t rand_word();
    logic [31:0] r;
    r = $urandom;
    return r[11:0];
  endfunction

  function automatic side_t rand_side();
    logic [31:0] r;
    side_t       s;
    r = $urandom;
    s = SIDE_IDLE;
    s.btn[0]       = r[0];   // Coin button only, btn[1] stays released
    s.key_mode     = r[1];
    s.video_toggle = r[2];
    s.scandbl_ctrl = r[4:3];
    return s;
  endfunction

  // Board shifter order, slot by slot
  function automatic logic slot_bit(input joy_word_t a, input joy_word_t b, input int k);
    case (k)
      2:  return a.start;
      3:  return a.aux_a;
      4:  return a.fire2;
      5:  return a.fire1;
      6:  return a.up;
      7:  return a.down;
      8:  return a.left;
      9:  return a.right;
      10: return b.start;
      11: return b.aux_a;
      12: return b.fire2;
      13: return b.fire1;
      14: return b.up;
      15: return b.down;
      16: return b.left;
      17: return b.right;
      18: return b.aux_c;
      19: return b.menu;
      20: return b.coin;
      21: return b.aux_b;
      22: return a.aux_c;
      23: return a.menu;
      24: return a.coin;
      default: return a.aux_b;   // Slot 25
    endcase
  endfunction

  task automatic apply_side(input side_t s);
    btn          = s.btn;
    key_reset    = s.key_reset;
    master_reset = s.master_reset;
    key_mode     = s.key_mode;
    video_toggle = s.video_toggle;
    scandbl_ctrl = s.scandbl_ctrl;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_pad(input string name, input joy_word_t exp_word,
                           input logic [5:0] act_stick, input logic act_start);
    if (act_stick !== exp_word[5:0] || act_start !== exp_word.start) begin
      $display("CHECK FAILED %s: expected stick %b start %b, actual stick %b start %b",
               name, exp_word[5:0], exp_word.start, act_stick, act_start);
      check_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp_val, act_val);
      check_errors++;
    end
  endtask

  task automatic check_count(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp_val, act_val);
      check_errors++;
    end
  endtask

  // Control rules against the published words and the current inputs
  task automatic check_controls(input string name, input side_t s);
    check_bit({name, " coin[0]"}, exp_a.coin & s.btn[0], coin[0]);
    check_bit({name, " coin[1]"}, exp_b.coin, coin[1]);
    check_bit({name, " machine_reset"}, s.key_reset | ~exp_a.menu | ~s.btn[1],
              machine_reset);
    check_bit({name, " reboot"}, s.master_reset | ~exp_b.menu, reboot);
    check_bit({name, " tv15khz_mode"}, ~s.scandbl_ctrl[1] ^ s.video_toggle, tv15khz_mode);
    check_bit({name, " led[0]"}, s.key_mode, led[0]);
    check_bit({name, " led[1]"}, s.scandbl_ctrl[0] ^ s.video_toggle, led[1]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Frame sequencing
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_load_fall(input int limit, output int cycles);
    int n;
    n      = 0;
    cycles = 0;
    if (aborted) return;
    do begin
      @(posedge ena_x);
      #1;
      n++;
    end while (joy_load && n < limit);
    if (joy_load) begin
      $display("Timeout: joy_load did not fall within %0d cycles", limit);
      timeout_errors++;
      aborted = 1'b1;
    end
    cycles = n;
  endtask

  // Starts in slot 0, ends in slot 0 of the next frame
  task automatic run_frame(input joy_word_t a, input joy_word_t b,
                           input side_t s, input string name);
    int          k;
    int          gap;
    logic [31:0] r;
    if (aborted) return;
    for (k = 1; k < `ARC_FRAME_SLOTS; k++) begin
      @(posedge ena_x);
      #1;
      if (!joy_load) begin
        $display("Protocol error: joy_load low in slot %0d of %s", k, name);
        protocol_errors++;
      end
      if (k == 2) begin   // Previous frame visible from slot 1 on
        check_pad({name, " pad_a"}, exp_a, stick_a, start[0]);
        check_pad({name, " pad_b"}, exp_b, stick_b, start[1]);
        apply_side(s);
      end
      if (k == 3) begin
        check_controls(name, s);
      end
      if (k >= `ARC_FIRST_SLOT) begin
        joy_data = slot_bit(a, b, k);
      end else begin
        r        = $urandom;
        joy_data = r[0];   // Ignored by the shifter
      end
    end
    exp_a = a;
    exp_b = b;
    wait_load_fall(1, gap);
  endtask

  task automatic check_warmup();
    int n;
    n = 0;
    do begin
      @(posedge ena_x);
      #1;
      n++;
      if (joy_load) begin
        check_bit("warm-up machine_reset", 1'b1, machine_reset);
      end
    end while (joy_load && n < `ARC_WARMUP_CYCLES + 30);
    if (joy_load) begin
      $display("Timeout: no joystick load after warm-up, waited %0d cycles", n);
      timeout_errors++;
      aborted = 1'b1;
    end else begin
      check_count("warm-up length", `ARC_WARMUP_CYCLES, n);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int        i;
    int        gap;
    side_t     s;
    joy_word_t menu_pad;
    ena_x           = 1'b0;
    pll_lckd        = 1'b0;
    joy_data        = 1'b1;
    apply_side(SIDE_IDLE);
    check_errors    = 0;
    protocol_errors = 0;
    timeout_errors  = 0;
    aborted         = 1'b0;
    exp_a           = PAD_IDLE;
    exp_b           = PAD_IDLE;
    void'($urandom(44));

    repeat (3) @(posedge ena_x);
    #1;
    check_bit("reset joy_load", 1'b1, joy_load);
    check_bit("reset machine_reset", 1'b1, machine_reset);
    check_pad("reset pad_a", PAD_IDLE, stick_a, start[0]);
    check_pad("reset pad_b", PAD_IDLE, stick_b, start[1]);
    repeat (2) @(posedge ena_x);
    #1;
    pll_lckd = 1'b1;
    check_bit("release joy_load", 1'b1, joy_load);
    check_bit("release machine_reset", 1'b1, machine_reset);
    check_pad("release pad_a", PAD_IDLE, stick_a, start[0]);
    check_pad("release pad_b", PAD_IDLE, stick_b, start[1]);
    check_warmup();
    run_frame(PAD_IDLE, PAD_IDLE, SIDE_IDLE, "first frame");

    // Joystick input stays high, pads remain released
    for (i = 0; i < 20 && !aborted; i++) begin
      wait_load_fall(40, gap);
      if (!aborted) check_count("frame period", `ARC_FRAME_SLOTS, gap);
    end

    for (i = 0; i < 50; i++) begin
      run_frame(rand_word(), rand_word(), SIDE_IDLE, $sformatf("pad frame %0d", i));
    end

    // Reset and reboot sources one at a time
    run_frame(PAD_IDLE, PAD_IDLE, SIDE_IDLE, "idle before sources");
    s = SIDE_IDLE;
    s.btn[1] = 1'b0;
    run_frame(PAD_IDLE, PAD_IDLE, s, "btn1 reset");
    s = SIDE_IDLE;
    s.key_reset = 1'b1;
    run_frame(PAD_IDLE, PAD_IDLE, s, "key reset");
    s = SIDE_IDLE;
    s.master_reset = 1'b1;
    run_frame(PAD_IDLE, PAD_IDLE, s, "master reset");
    menu_pad = PAD_IDLE;
    menu_pad.menu = 1'b0;
    run_frame(menu_pad, PAD_IDLE, SIDE_IDLE, "pad_a menu load");
    run_frame(PAD_IDLE, menu_pad, SIDE_IDLE, "pad_a menu reset");
    run_frame(PAD_IDLE, PAD_IDLE, SIDE_IDLE, "pad_b menu reboot");
    run_frame(PAD_IDLE, PAD_IDLE, SIDE_IDLE, "sources released");

    for (i = 0; i < 40; i++) begin
      run_frame(rand_word(), rand_word(), rand_side(), $sformatf("coin video frame %0d", i));
    end

    $display("Errors: check %0d, protocol %0d, timeout %0d",
             check_errors, protocol_errors, timeout_errors);
    if (check_errors == 0 && protocol_errors == 0 && timeout_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
